//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
TOP        := tb_mcu_subsys
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/mcu_bus_pkg.sv
package mcu_bus_pkg;

    ////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////
    localparam int BUS_AW    = 8;
    localparam int BUS_DW    = 8;
    localparam int RAM_DEPTH = 128;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);
    localparam int REG_IW    = 3;

    // Top address bit picks RAM or timer registers
    localparam logic REGION_RAM = 1'b0;
    localparam logic REGION_REG = 1'b1;

    ////////////////////////////////////////
    // Timer register map
    ////////////////////////////////////////
    localparam logic [REG_IW-1:0] REG_CTRL     = 3'd0;
    localparam logic [REG_IW-1:0] REG_RELOAD   = 3'd1;
    localparam logic [REG_IW-1:0] REG_COUNT    = 3'd2;
    localparam logic [REG_IW-1:0] REG_STATUS   = 3'd3;
    localparam logic [REG_IW-1:0] REG_PRESCALE = 3'd4;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_TMR_EN_BIT = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int STATUS_FLAG_BIT = 0;

    // One bus cycle as issued by the SPI slave
    typedef struct packed {
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] wdata;
        logic              wr;
        logic              rd;
    } bus_req_t;

    typedef struct packed {
        logic              region;
        logic [RAM_AW-1:0] offset;
    } ram_view_t;

    typedef struct packed {
        logic                       region;
        logic [BUS_AW-REG_IW-2:0]   spare;
        logic [REG_IW-1:0]          idx;
    } reg_view_t;

    typedef union packed {
        ram_view_t ram;
        reg_view_t regs;
    } bus_addr_u;

endpackage

//--- design/mcu_bus_decode.sv
`timescale 1ns/1ps

module mcu_bus_decode
    import mcu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  bus_req_t          bus_req,
    input  logic [BUS_DW-1:0] ram_rdata,
    input  logic [BUS_DW-1:0] reg_rdata,
    output logic              ram_en,
    output logic              ram_we,
    output logic [RAM_AW-1:0] ram_addr,
    output logic [BUS_DW-1:0] ram_wdata,
    output logic              reg_we,
    output logic [REG_IW-1:0] reg_idx,
    output logic [BUS_DW-1:0] reg_wdata,
    output logic [BUS_DW-1:0] rdata
);

    bus_addr_u addr_v;
    logic      is_ram;
    logic      rd_region;

    assign addr_v = bus_req.addr;
    assign is_ram = (addr_v.ram.region == REGION_RAM);

    // RAM side
    assign ram_en    = (bus_req.wr || bus_req.rd) && is_ram;
    assign ram_we    = bus_req.wr && is_ram;
    assign ram_addr  = addr_v.ram.offset;
    assign ram_wdata = bus_req.wdata;

    // Timer register side
    assign reg_we    = bus_req.wr && !is_ram;
    assign reg_idx   = addr_v.regs.idx;
    assign reg_wdata = bus_req.wdata;

    // Region of the read in flight, used to steer the returning data
    always_ff @(posedge clk) begin
        if (rst)
            rd_region <= REGION_RAM;
        else if (bus_req.rd)
            rd_region <= addr_v.regs.region;
    end

    assign rdata = (rd_region == REGION_REG) ? reg_rdata : ram_rdata;

endmodule

//--- design/mcu_subsys_top.sv
`timescale 1ns/1ps

module mcu_subsys_top
    import mcu_bus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic irq
);

    bus_req_t          bus_req;
    logic [BUS_DW-1:0] bus_rdata;

    // RAM port
    logic              ram_en;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    logic [BUS_DW-1:0] ram_wdata;
    logic [BUS_DW-1:0] ram_rdata;

    // Timer register port
    logic              reg_we;
    logic [REG_IW-1:0] reg_idx;
    logic [BUS_DW-1:0] reg_wdata;
    logic [BUS_DW-1:0] reg_rdata;

    // Timer config and status
    logic              tmr_en;
    logic [BUS_DW-1:0] tmr_reload;
    logic [BUS_DW-1:0] tmr_prescale;
    logic [BUS_DW-1:0] tmr_count;
    logic              tmr_expire;

    mcu_spi_slave u_spi (
        .clk      (clk),
        .rst      (rst),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .rdata    (bus_rdata),
        .spi_miso (spi_miso),
        .bus_req  (bus_req)
    );

    mcu_bus_decode u_dec (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .ram_rdata (ram_rdata),
        .reg_rdata (reg_rdata),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .reg_we    (reg_we),
        .reg_idx   (reg_idx),
        .reg_wdata (reg_wdata),
        .rdata     (bus_rdata)
    );

    scratch_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    timer_regs u_tregs (
        .clk      (clk),
        .rst      (rst),
        .we       (reg_we),
        .idx      (reg_idx),
        .wdata    (reg_wdata),
        .count    (tmr_count),
        .expire   (tmr_expire),
        .rdata    (reg_rdata),
        .tmr_en   (tmr_en),
        .reload   (tmr_reload),
        .prescale (tmr_prescale),
        .irq      (irq)
    );

    timer_core u_tcore (
        .clk      (clk),
        .rst      (rst),
        .en       (tmr_en),
        .reload   (tmr_reload),
        .prescale (tmr_prescale),
        .count    (tmr_count),
        .expire   (tmr_expire)
    );

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram
    import mcu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [BUS_DW-1:0] wdata,
    output logic [BUS_DW-1:0] rdata
);

    logic [BUS_DW-1:0] mem [RAM_DEPTH];

    // Single port, read returns old data on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];
        end
    end

endmodule

//--- files.f
common/mcu_bus_pkg.sv
mcu_if/mcu_spi_slave.sv
design/mcu_bus_decode.sv
design/scratch_ram.sv
timer/timer_regs.sv
timer/timer_core.sv
design/mcu_subsys_top.sv
tests/tb_mcu_subsys.sv

//--- mcu_if/mcu_spi_slave.sv
`timescale 1ns/1ps

module mcu_spi_slave
    import mcu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              spi_cs,
    input  logic              spi_sck,
    input  logic              spi_mosi,
    input  logic [BUS_DW-1:0] rdata,
    output logic              spi_miso,
    output bus_req_t          bus_req
);

    ////////////////////////////////////////
    // Pin synchronisers
    ////////////////////////////////////////

    // Two stages to sync, third stage holds previous value for edges
    logic [2:0] cs_sync;
    logic [2:0] sck_sync;
    logic [1:0] mosi_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync   <= 3'b111;
            sck_sync  <= 3'b000;
            mosi_sync <= 2'b00;
        end else begin
            cs_sync   <= {cs_sync[1:0], spi_cs};
            sck_sync  <= {sck_sync[1:0], spi_sck};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    logic cs_active;
    logic cs_rise;
    logic sck_rise;
    logic sck_fall;
    logic mosi_bit;

    assign cs_active = !cs_sync[1];
    assign cs_rise   = (cs_sync[2:1] == 2'b01);
    assign sck_rise  = (sck_sync[2:1] == 2'b01);
    assign sck_fall  = (sck_sync[2:1] == 2'b10);
    assign mosi_bit  = mosi_sync[1];

    ////////////////////////////////////////
    // Frame shifting and counting
    ////////////////////////////////////////
    logic [2:0]        bit_cnt;
    logic [1:0]        byte_cnt;
    logic [BUS_AW-1:0] addr_sr;
    logic [BUS_DW-1:0] data_sr;
    logic              ignore_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
        end else if (!cs_active) begin
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            // Saturate so oversized frames stay ignored
            if (bit_cnt == 3'd7 && byte_cnt != 2'd3)
                byte_cnt <= byte_cnt + 2'd1;
        end
    end

    // First byte is the address, second the write data
    always_ff @(posedge clk) begin
        if (cs_active && sck_rise) begin
            if (byte_cnt == 2'd0)
                addr_sr <= {addr_sr[BUS_AW-2:0], mosi_bit};
            else if (byte_cnt == 2'd1)
                data_sr <= {data_sr[BUS_DW-2:0], mosi_bit};
        end
    end

    // Frame classification at CS release
    logic frame_rd;
    logic frame_wr;

    assign frame_rd = cs_rise && !ignore_next && (byte_cnt == 2'd1);
    assign frame_wr = cs_rise && !ignore_next && (byte_cnt == 2'd2);

    // Any frame after a read carries the read data out and is dropped
    always_ff @(posedge clk) begin
        if (rst)
            ignore_next <= 1'b0;
        else if (cs_rise)
            ignore_next <= !ignore_next && (byte_cnt == 2'd1);
    end

    ////////////////////////////////////////
    // Bus strobes
    ////////////////////////////////////////
    logic              req_wr;
    logic              req_rd;
    logic              rd_pend;
    logic [BUS_AW-1:0] req_addr;
    logic [BUS_DW-1:0] req_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_wr  <= 1'b0;
            req_rd  <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            req_wr  <= frame_wr;
            req_rd  <= frame_rd;
            // Read data shows up one cycle after the strobe
            rd_pend <= req_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_wr || frame_rd) begin
            req_addr  <= addr_sr;
            req_wdata <= data_sr;
        end
    end

    assign bus_req = '{addr: req_addr, wdata: req_wdata, wr: req_wr, rd: req_rd};

    ////////////////////////////////////////
    // MISO shift register
    ////////////////////////////////////////
    logic [BUS_DW-1:0] miso_sr;

    always_ff @(posedge clk) begin
        if (rst)
            miso_sr <= '0;
        else if (rd_pend)
            miso_sr <= rdata;
        else if (cs_active && sck_fall)
            miso_sr <= {miso_sr[BUS_DW-2:0], 1'b0};
    end

    // MSB sits on the pin before the first SCK rise
    assign spi_miso = miso_sr[BUS_DW-1];

endmodule

//--- tests/spi_stimulus.txt
// Columns are op, address, data, expected value, all hex
// Ops 1 write, 2 read, 3 read then ignored 16-bit write, 4 wait irq (data cycles), 5 irq level
5 00 00 00
2 80 00 00
2 81 00 00
2 84 00 00
2 83 00 00
1 00 a5 00
1 7f 3c 00
1 42 96 00
2 00 00 a5
2 7f 00 3c
2 42 00 96
1 80 02 00
1 81 05 00
1 84 03 00
2 80 00 02
2 81 00 05
2 84 00 03
2 85 00 00
2 86 00 00
2 87 00 00
3 42 e1 96
2 42 00 96
1 80 03 00
4 00 80 00
1 80 02 00
5 00 00 01
2 83 00 01
1 83 01 00
5 00 00 00
2 83 00 00
1 80 01 00
2 83 00 01
5 00 00 00

//--- tests/tb_mcu_subsys.sv
`timescale 1ns/1ps

module tb_mcu_subsys;

    // Operation codes in the stimulus file
    localparam logic [7:0] OP_WRITE     = 8'h01;
    localparam logic [7:0] OP_READ      = 8'h02;
    localparam logic [7:0] OP_READ_IGN  = 8'h03;
    localparam logic [7:0] OP_WAIT_IRQ  = 8'h04;
    localparam logic [7:0] OP_CHECK_IRQ = 8'h05;

    // Worst line is an address frame plus a 16-bit follower, each with CS gaps
    localparam int OP_CYCLES = (8 + 16) * 16 + 2 * 24;
    localparam int MARGIN    = 500;

    typedef struct packed {
        logic [7:0] code;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] expd;
    } stim_op_t;

    logic clk = 1'b0;
    logic rst;
    logic spi_cs;
    logic spi_sck;
    logic spi_mosi;
    logic spi_miso;
    logic irq;

    stim_op_t ops[$];
    int       cycle_limit = 0;
    int       cycle_cnt = 0;

    always #50 clk = ~clk;

    mcu_subsys_top uut (
        .clk      (clk),
        .rst      (rst),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .irq      (irq)
    );

    // Run length guard that arms once the stimulus is loaded
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Checking and SPI driving
    ////////////////////////////////////////
    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s gave 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    // One SCK period of 8 clk low then 8 clk high
    task automatic shift_bit(input logic mosi_val, output logic miso_val);
        @(posedge clk);
        spi_sck  <= 1'b0;
        spi_mosi <= mosi_val;
        repeat (8) @(posedge clk);
        spi_sck <= 1'b1;
        // MISO settled long before the rising edge
        @(negedge clk);
        miso_val = spi_miso;
        repeat (7) @(posedge clk);
    endtask

    // Sends tx MSB first, returns the MISO bits left aligned in rx
    task automatic run_frame(input int nbits, input logic [15:0] tx,
                             output logic [15:0] rx);
        logic [15:0] tx_sr;
        logic        b;
        int          i;

        tx_sr = tx;
        rx    = '0;
        @(posedge clk);
        spi_cs <= 1'b0;
        for (i = 0; i < nbits; i++) begin
            shift_bit(tx_sr[15], b);
            tx_sr = {tx_sr[14:0], 1'b0};
            rx    = {rx[14:0], b};
        end
        rx = rx << (16 - nbits);
        @(posedge clk);
        spi_sck <= 1'b0;
        @(posedge clk);
        spi_cs <= 1'b1;
        // CS high long enough for the bus cycle and MISO load
        repeat (16) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        stim_op_t    op;
        logic [7:0]  f_code;
        logic [7:0]  f_addr;
        logic [7:0]  f_data;
        logic [7:0]  f_expd;
        logic [15:0] rx;
        string       line;
        int          fd;
        int          longest_wait;
        int          waited;

        rst      <= 1'b1;
        spi_cs   <= 1'b1;
        spi_sck  <= 1'b0;
        spi_mosi <= 1'b0;

        fd = $fopen("tests/spi_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/spi_stimulus.txt");
            $display("Test failures found");
            $fatal(1, "no stimulus");
        end
        // Comment and blank lines fail the scan and are skipped
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h", f_code, f_addr, f_data, f_expd) == 4) begin
                op = {f_code, f_addr, f_data, f_expd};
                ops.push_back(op);
            end
        end
        $fclose(fd);

        longest_wait = 0;
        foreach (ops[n]) begin
            if (ops[n].code == OP_WAIT_IRQ && int'(ops[n].data) > longest_wait)
                longest_wait = int'(ops[n].data);
        end
        cycle_limit = ops.size() * OP_CYCLES + longest_wait + MARGIN;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        foreach (ops[n]) begin
            op = ops[n];
            case (op.code)
                OP_WRITE: run_frame(16, {op.addr, op.data}, rx);
                OP_READ: begin
                    run_frame(8, {op.addr, 8'h00}, rx);
                    run_frame(8, 16'h0000, rx);
                    check_value(rx[15:8], op.expd, $sformatf("read of 0x%02h", op.addr));
                end
                OP_READ_IGN: begin
                    run_frame(8, {op.addr, 8'h00}, rx);
                    // Follower holds a write pattern that must not reach the bus
                    run_frame(16, {op.addr, op.data}, rx);
                    check_value(rx[15:8], op.expd, $sformatf("read of 0x%02h", op.addr));
                end
                OP_WAIT_IRQ: begin
                    waited = 0;
                    @(negedge clk);
                    while (irq !== 1'b1 && waited < int'(op.data)) begin
                        @(negedge clk);
                        waited++;
                    end
                    check_value({7'd0, irq}, 8'h01, "irq after timer wait");
                end
                OP_CHECK_IRQ: begin
                    @(negedge clk);
                    check_value({7'd0, irq}, op.expd, "irq level");
                end
                default: begin
                    $display("Unknown operation code 0x%02h on stimulus entry %0d",
                             op.code, n);
                    $display("Test failures found");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- timer/timer_core.sv
`timescale 1ns/1ps

module timer_core
    import mcu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [BUS_DW-1:0] reload,
    input  logic [BUS_DW-1:0] prescale,
    output logic [BUS_DW-1:0] count,
    output logic              expire
);

    logic [BUS_DW-1:0] pre_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
            count   <= '0;
            expire  <= 1'b0;
        end else if (!en) begin
            // Hold at load values until enabled
            pre_cnt <= prescale;
            count   <= reload;
            expire  <= 1'b0;
        end else begin
            expire <= 1'b0;
            if (pre_cnt == '0) begin
                pre_cnt <= prescale;
                // One main count step every prescale+1 clocks
                if (count == '0) begin
                    count  <= reload;
                    expire <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end else begin
                pre_cnt <= pre_cnt - 1'b1;
            end
        end
    end

endmodule

//--- timer/timer_regs.sv
`timescale 1ns/1ps

module timer_regs
    import mcu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  logic [REG_IW-1:0] idx,
    input  logic [BUS_DW-1:0] wdata,
    input  logic [BUS_DW-1:0] count,
    input  logic              expire,
    output logic [BUS_DW-1:0] rdata,
    output logic              tmr_en,
    output logic [BUS_DW-1:0] reload,
    output logic [BUS_DW-1:0] prescale,
    output logic              irq
);

    logic [BUS_DW-1:0] ctrl;
    logic              flag;

    ////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= '0;
            reload   <= '0;
            prescale <= '0;
        end else if (we) begin
            case (idx)
                REG_CTRL:     ctrl     <= wdata;
                REG_RELOAD:   reload   <= wdata;
                REG_PRESCALE: prescale <= wdata;
                default:      ;
            endcase
        end
    end

    // Expiry flag, set beats write-one-to-clear
    always_ff @(posedge clk) begin
        if (rst)
            flag <= 1'b0;
        else if (expire)
            flag <= 1'b1;
        else if (we && idx == REG_STATUS && wdata[STATUS_FLAG_BIT])
            flag <= 1'b0;
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (idx)
            REG_CTRL:     rdata <= ctrl;
            REG_RELOAD:   rdata <= reload;
            REG_COUNT:    rdata <= count;
            REG_STATUS:   rdata <= {{(BUS_DW-1){1'b0}}, flag};
            REG_PRESCALE: rdata <= prescale;
            default:      rdata <= '0;
        endcase
    end

    assign tmr_en = ctrl[CTRL_TMR_EN_BIT];
    assign irq    = flag && ctrl[CTRL_IRQ_EN_BIT];

endmodule
